// ==== project.f ====
source/vfu_pkg.sv
source/vfu_req_if.sv
source/vfu_sys_if.sv
source/vfu_fifo.sv
source/vfu_frontend.sv
source/vfu_insn_queues.sv
source/vfu_resp_arbiter.sv
source/vfu_top.sv
dv/vfu_tb.sv

// ==== Bender.yml ====
package:
  name: vfu

sources:
  - source/vfu_pkg.sv
  - source/vfu_req_if.sv
  - source/vfu_sys_if.sv
  - source/vfu_fifo.sv
  - source/vfu_frontend.sv
  - source/vfu_insn_queues.sv
  - source/vfu_resp_arbiter.sv
  - source/vfu_top.sv
  - target: test
    files:
      - dv/vfu_tb.sv

// ==== dv/vfu_stim.txt ====
// wait id state func insn data0 data1 backend_result expected_resp_data
// wait 0 none, 1 wait for idle, 2 wait for idle then stall the back end
0 1 0 000 01000057 00000011 00000012 11111111 11111111
0 2 1 000 02000057 00000021 00000022 22222222 22222222
0 3 0 000 03000057 00000031 00000032 33333333 33333333
0 4 0 3f0 0000000b 00000000 00000000 00000000 00000000
0 5 1 000 05000057 00000051 00000052 55555555 55555555
1 6 0 000 0000000b 00000000 00000000 00000000 00000004
0 7 0 001 0000000b 00000000 00000000 00000000 00000001
2 8 0 000 08000057 00000081 00000082 a0000008 a0000008
0 9 0 000 09000057 00000091 00000092 a0000009 a0000009
0 a 0 000 0a000057 000000a1 000000a2 a000000a a000000a
0 b 0 000 0b000057 000000b1 000000b2 a000000b a000000b
0 c 0 000 0c000057 000000c1 000000c2 a000000c a000000c
0 d 0 000 0d000057 000000d1 000000d2 a000000d a000000d
0 e 0 000 0e000057 000000e1 000000e2 a000000e a000000e
0 f 0 000 0f000057 000000f1 000000f2 a000000f a000000f
0 0 0 000 10000057 00000101 00000102 a0000010 a0000010
0 1 0 000 11000057 00000111 00000112 a0000011 a0000011
0 2 0 000 12000057 00000121 00000122 a0000012 a0000012
0 3 0 000 13000057 00000131 00000132 a0000013 a0000013
1 4 0 000 0000000b 00000000 00000000 00000000 00000010
0 5 1 3f2 0000000b 00000000 00000000 00000000 00000000
1 6 1 001 0000000b 00000000 00000000 00000000 00000002

// ==== dv/vfu_tb.sv ====
`timescale 1ns/1ns

module vfu_tb import vfu_pkg::*; ();

    localparam int FIELDS    = 9;
    localparam int MAX_LINES = 64;
    localparam int NUM_IDS   = 2**REQ_ID_W;

    logic      i_clk = 1'b0;
    logic      i_rst;
    logic      i_req_valid;
    logic      o_req_ready;
    req_id_t   i_req_id;
    state_id_t i_req_state;
    func_t     i_req_func;
    insn_t     i_req_insn;
    xlen_t     i_req_data0;
    xlen_t     i_req_data1;
    logic      o_issue_valid;
    logic      i_issue_ready;
    insn_t     o_issue_insn;
    xlen_t     o_issue_data0;
    xlen_t     o_issue_data1;
    state_id_t o_issue_state;
    req_id_t   o_issue_id;
    logic      i_exec_valid;
    xlen_t     i_exec_data;
    logic      o_resp_valid;
    logic      i_resp_ready;
    xlen_t     o_resp_data;
    req_id_t   o_resp_id;

    logic [31:0] stim_mem [FIELDS*MAX_LINES];
    int          num_lines;
    int          cycle_limit;
    int          cycles;
    logic [31:0] lcg_state;

    // Per-id bookkeeping for requests in flight
    logic [NUM_IDS-1:0] outstanding;
    logic [NUM_IDS-1:0] vec_tab;
    logic [NUM_IDS-1:0] fence_tab;
    int                 seq_tab [NUM_IDS];
    xlen_t              exp_data [NUM_IDS];
    xlen_t              result_tab [NUM_IDS];

    // Expected issue order per state, id above insn above both operands
    logic [REQ_ID_W+INSN_W+2*XLEN-1:0] issue_q0 [$];
    logic [REQ_ID_W+INSN_W+2*XLEN-1:0] issue_q1 [$];
    xlen_t                             exec_q [$];

    int   exec_wait;
    int   in_flight;
    logic stall;
    logic stall_seen;
    logic saw_full;

    vfu_top u_vfu_top (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (i_req_valid),
        .o_req_ready   (o_req_ready),
        .i_req_id      (i_req_id),
        .i_req_state   (i_req_state),
        .i_req_func    (i_req_func),
        .i_req_insn    (i_req_insn),
        .i_req_data0   (i_req_data0),
        .i_req_data1   (i_req_data1),
        .o_issue_valid (o_issue_valid),
        .i_issue_ready (i_issue_ready),
        .o_issue_insn  (o_issue_insn),
        .o_issue_data0 (o_issue_data0),
        .o_issue_data1 (o_issue_data1),
        .o_issue_state (o_issue_state),
        .o_issue_id    (o_issue_id),
        .i_exec_valid  (i_exec_valid),
        .i_exec_data   (i_exec_data),
        .o_resp_valid  (o_resp_valid),
        .i_resp_ready  (i_resp_ready),
        .o_resp_data   (o_resp_data),
        .o_resp_id     (o_resp_id)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_id(input string name, input req_id_t got, input req_id_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_insn(input string name, input insn_t got, input insn_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic wait_idle();
        while (outstanding != '0) begin
            @(negedge i_clk);
        end
    endtask

    task automatic send_request(input req_id_t id, input state_id_t st, input func_t fn,
                                input insn_t insn, input xlen_t d0, input xlen_t d1);
        i_req_valid = 1'b1;
        i_req_id    = id;
        i_req_state = st;
        i_req_func  = fn;
        i_req_insn  = insn;
        i_req_data0 = d0;
        i_req_data1 = d1;
        @(posedge i_clk);
        while (!o_req_ready) begin
            @(posedge i_clk);
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;
    endtask

    initial begin
        forever #4 i_clk = ~i_clk;
    end

    ////////////////////
    // Back-end model
    ////////////////////

    always @(negedge i_clk) begin : back_end
        logic [31:0] rnd_issue;
        logic [31:0] rnd_resp;
        logic [31:0] rnd_delay;
        rnd_issue = lcg_next();
        rnd_resp  = lcg_next();
        // Never more results in flight than the response side can hold
        i_issue_ready = !stall_seen && (in_flight < RESP_DEPTH) && (rnd_issue[17:16] != 2'b00);
        i_resp_ready  = (rnd_resp[17:16] != 2'b00);
        i_exec_valid  = 1'b0;
        if (exec_q.size() > 0) begin
            if (exec_wait == 0) begin
                rnd_delay    = lcg_next();
                i_exec_valid = 1'b1;
                i_exec_data  = exec_q.pop_front();
                exec_wait    = int'(rnd_delay[17:16]);
            end else begin
                exec_wait = exec_wait - 1;
            end
        end
    end

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge i_clk) begin : monitor
        logic [REQ_ID_W+INSN_W+2*XLEN-1:0] exp_issue;
        req_id_t                           rid;
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
        end
        if (stall_seen && !o_req_ready) begin
            saw_full = 1'b1;
        end
        stall_seen = stall;
        if (!i_rst && o_issue_valid && i_issue_ready) begin
            if (o_issue_state == state_id_t'(0) && issue_q0.size() > 0) begin
                exp_issue = issue_q0.pop_front();
            end else if (o_issue_state != state_id_t'(0) && issue_q1.size() > 0) begin
                exp_issue = issue_q1.pop_front();
            end else begin
                stop_run($sformatf("issue from state %0d with no operation sent to it",
                                   o_issue_state));
            end
            check_id("o_issue_id", o_issue_id, exp_issue[2*XLEN+INSN_W +: REQ_ID_W]);
            check_insn("o_issue_insn", o_issue_insn, exp_issue[2*XLEN +: INSN_W]);
            check_data("o_issue_data0", o_issue_data0, exp_issue[XLEN +: XLEN]);
            check_data("o_issue_data1", o_issue_data1, exp_issue[0 +: XLEN]);
            exec_q.push_back(result_tab[o_issue_id]);
            in_flight = in_flight + 1;
        end
        if (!i_rst && o_resp_valid && i_resp_ready) begin
            rid = o_resp_id;
            if (!outstanding[rid]) begin
                stop_run($sformatf("response for id %0d that was not outstanding", rid));
            end
            // A fence may not overtake an older vector operation
            if (fence_tab[rid]) begin
                for (int i = 0; i < NUM_IDS; i++) begin
                    if (outstanding[i] && vec_tab[i] && seq_tab[i] < seq_tab[rid]) begin
                        stop_run($sformatf("fence id %0d answered before vector id %0d", rid, i));
                    end
                end
            end
            check_data("o_resp_data", o_resp_data, exp_data[rid]);
            outstanding[rid] = 1'b0;
            if (vec_tab[rid]) begin
                in_flight = in_flight - 1;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : driver
        int          base;
        logic [31:0] flag;
        req_id_t     id;
        state_id_t   st;
        func_t       fn;
        insn_t       insn;
        xlen_t       d0;
        xlen_t       d1;
        i_rst         = 1'b1;
        i_req_valid   = 1'b0;
        i_req_id      = '0;
        i_req_state   = '0;
        i_req_func    = '0;
        i_req_insn    = '0;
        i_req_data0   = '0;
        i_req_data1   = '0;
        i_issue_ready = 1'b0;
        i_exec_valid  = 1'b0;
        i_exec_data   = '0;
        i_resp_ready  = 1'b0;
        lcg_state     = 32'd66;
        cycles        = 0;
        in_flight     = 0;
        exec_wait     = 0;
        stall         = 1'b0;
        stall_seen    = 1'b0;
        saw_full      = 1'b0;
        outstanding   = '0;
        vec_tab       = '0;
        fence_tab     = '0;
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            stim_mem[i] = 'x;
        end
        $readmemh("dv/vfu_stim.txt", stim_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && !$isunknown(stim_mem[num_lines*FIELDS])) begin
            num_lines = num_lines + 1;
        end
        cycle_limit = 40 * num_lines + 200;
        if (num_lines == 0) begin
            stop_run("no stimulus lines read from dv/vfu_stim.txt");
        end

        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check_flag("o_issue_valid", o_issue_valid, 1'b0);
        check_flag("o_resp_valid", o_resp_valid, 1'b0);
        check_flag("o_req_ready", o_req_ready, 1'b1);

        for (int line = 0; line < num_lines; line++) begin
            base = line * FIELDS;
            flag = stim_mem[base];
            if (flag != 32'd0) begin
                stall = 1'b0;
                wait_idle();
            end
            if (flag == 32'd2) begin
                stall = 1'b1;
            end
            id   = req_id_t'(stim_mem[base+1]);
            st   = state_id_t'(stim_mem[base+2]);
            fn   = func_t'(stim_mem[base+3]);
            insn = insn_t'(stim_mem[base+4]);
            d0   = stim_mem[base+5];
            d1   = stim_mem[base+6];
            // Id reuse waits for the earlier response
            while (outstanding[id]) begin
                @(negedge i_clk);
            end
            outstanding[id] = 1'b1;
            fence_tab[id]   = is_fence(insn, fn);
            vec_tab[id]     = !is_fence(insn, fn) && !is_perf(insn, fn);
            seq_tab[id]     = line;
            result_tab[id]  = stim_mem[base+7];
            exp_data[id]    = stim_mem[base+8];
            if (vec_tab[id] && st == state_id_t'(0)) begin
                issue_q0.push_back({id, insn, d0, d1});
            end else if (vec_tab[id]) begin
                issue_q1.push_back({id, insn, d0, d1});
            end
            send_request(id, st, fn, insn, d0, d1);
        end
        stall = 1'b0;
        wait_idle();

        if (saw_full && issue_q0.size() == 0 && issue_q1.size() == 0 && exec_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else if (!saw_full) begin
            stop_run("o_req_ready never dropped while the back end was stalled");
        end else begin
            stop_run("expected issues or results left over at the end of the run");
        end
    end

endmodule

// ==== source/vfu_top.sv ====
`timescale 1ns/1ns

module vfu_top import vfu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    // Requests
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  req_id_t   i_req_id,
    input  state_id_t i_req_state,
    input  func_t     i_req_func,
    input  insn_t     i_req_insn,
    input  xlen_t     i_req_data0,
    input  xlen_t     i_req_data1,
    // Issue to the vector back end
    output logic      o_issue_valid,
    input  logic      i_issue_ready,
    output insn_t     o_issue_insn,
    output xlen_t     o_issue_data0,
    output xlen_t     o_issue_data1,
    output state_id_t o_issue_state,
    output req_id_t   o_issue_id,
    // Execute results
    input  logic      i_exec_valid,
    input  xlen_t     i_exec_data,
    // Responses
    output logic      o_resp_valid,
    input  logic      i_resp_ready,
    output xlen_t     o_resp_data,
    output req_id_t   o_resp_id
);

    logic queues_empty;
    logic rvv_pending;
    logic issue_fire;

    vfu_req_if req_bus ();
    vfu_sys_if sys_bus ();

    vfu_frontend u_frontend (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req_id       (i_req_id),
        .i_req_state    (i_req_state),
        .i_req_func     (i_req_func),
        .i_req_insn     (i_req_insn),
        .i_req_data0    (i_req_data0),
        .i_req_data1    (i_req_data1),
        .i_queues_empty (queues_empty),
        .i_rvv_pending  (rvv_pending),
        .req            (req_bus.src),
        .sys            (sys_bus.src)
    );

    vfu_insn_queues u_insn_queues (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .req           (req_bus.dst),
        .o_empty       (queues_empty),
        .o_issue_valid (o_issue_valid),
        .i_issue_ready (i_issue_ready),
        .o_issue_insn  (o_issue_insn),
        .o_issue_data0 (o_issue_data0),
        .o_issue_data1 (o_issue_data1),
        .o_issue_state (o_issue_state),
        .o_issue_fire  (issue_fire),
        .o_issue_id    (o_issue_id)
    );

    vfu_resp_arbiter u_resp_arbiter (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .sys           (sys_bus.dst),
        .i_issue_fire  (issue_fire),
        .i_issue_id    (o_issue_id),
        .i_exec_valid  (i_exec_valid),
        .i_exec_data   (i_exec_data),
        .o_rvv_pending (rvv_pending),
        .o_resp_valid  (o_resp_valid),
        .i_resp_ready  (i_resp_ready),
        .o_resp_data   (o_resp_data),
        .o_resp_id     (o_resp_id)
    );

endmodule

// ==== source/vfu_resp_arbiter.sv ====
`timescale 1ns/1ns

module vfu_resp_arbiter import vfu_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    vfu_sys_if.dst  sys,
    input  logic    i_issue_fire,
    input  req_id_t i_issue_id,
    input  logic    i_exec_valid,
    input  xlen_t   i_exec_data,
    output logic    o_rvv_pending,
    output logic    o_resp_valid,
    input  logic    i_resp_ready,
    output xlen_t   o_resp_data,
    output req_id_t o_resp_id
);

    req_id_t fence_id;
    req_id_t rvv_id;
    req_id_t perf_id;
    xlen_t   rvv_data;
    xlen_t   perf_data;
    xlen_t   perf_sample;

    logic fence_id_valid;
    logic fence_id_full;
    logic rvv_id_valid;
    logic rvv_data_valid;
    logic perf_id_valid;
    logic perf_id_full;
    logic perf_data_valid;

    logic fence_ready;
    logic rvv_ready;
    logic perf_ready;
    logic fence_pop;
    logic rvv_pop;
    logic perf_pop;
    logic accept;

    xlen_t cnt_issued;
    xlen_t cnt_fences;

    resp_port_t port;
    resp_port_t held_port;
    logic       held;

    ////////////////////
    // Buffers
    ////////////////////

    vfu_fifo #(.WIDTH(REQ_ID_W), .DEPTH(RESP_DEPTH)) u_fence_id (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (sys.fence_push),
        .i_pop   (fence_pop),
        .i_data  (sys.id),
        .o_data  (fence_id),
        .o_valid (fence_id_valid),
        .o_full  (fence_id_full)
    );

    // Vector ids in issue order, results arrive in the same order
    vfu_fifo #(.WIDTH(REQ_ID_W), .DEPTH(RESP_DEPTH)) u_rvv_id (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_issue_fire),
        .i_pop   (rvv_pop),
        .i_data  (i_issue_id),
        .o_data  (rvv_id),
        .o_valid (rvv_id_valid),
        .o_full  ()
    );

    vfu_fifo #(.WIDTH(XLEN), .DEPTH(RESP_DEPTH)) u_rvv_data (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (i_exec_valid),
        .i_pop   (rvv_pop),
        .i_data  (i_exec_data),
        .o_data  (rvv_data),
        .o_valid (rvv_data_valid),
        .o_full  ()
    );

    vfu_fifo #(.WIDTH(REQ_ID_W), .DEPTH(RESP_DEPTH)) u_perf_id (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (sys.perf_push),
        .i_pop   (perf_pop),
        .i_data  (sys.id),
        .o_data  (perf_id),
        .o_valid (perf_id_valid),
        .o_full  (perf_id_full)
    );

    vfu_fifo #(.WIDTH(XLEN), .DEPTH(RESP_DEPTH)) u_perf_data (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (sys.perf_push),
        .i_pop   (perf_pop),
        .i_data  (perf_sample),
        .o_data  (perf_data),
        .o_valid (perf_data_valid),
        .o_full  ()
    );

    assign sys.full      = fence_id_full | perf_id_full;
    assign o_rvv_pending = rvv_id_valid;
    assign perf_sample   = (sys.sel == CNT_FENCES) ? cnt_fences : cnt_issued;

    ////////////////////
    // Response mux
    ////////////////////

    assign fence_ready = fence_id_valid;
    assign rvv_ready   = rvv_id_valid & rvv_data_valid;
    assign perf_ready  = perf_id_valid & perf_data_valid;

    // Fixed priority, locked while a response waits
    always_comb begin
        if (held) begin
            port = held_port;
        end else if (fence_ready) begin
            port = FENCE;
        end else if (rvv_ready) begin
            port = RVV;
        end else begin
            port = PERF;
        end
    end

    always_comb begin
        case (port)
            FENCE: begin
                o_resp_valid = fence_ready;
                o_resp_id    = fence_id;
                o_resp_data  = '0;
            end
            RVV: begin
                o_resp_valid = rvv_ready;
                o_resp_id    = rvv_id;
                o_resp_data  = rvv_data;
            end
            default: begin
                o_resp_valid = perf_ready;
                o_resp_id    = perf_id;
                o_resp_data  = perf_data;
            end
        endcase
    end

    assign accept    = o_resp_valid & i_resp_ready;
    assign fence_pop = accept & (port == FENCE);
    assign rvv_pop   = accept & (port == RVV);
    assign perf_pop  = accept & (port == PERF);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            held       <= 1'b0;
            held_port  <= FENCE;
            cnt_issued <= '0;
            cnt_fences <= '0;
        end else begin
            held      <= o_resp_valid & ~i_resp_ready;
            held_port <= port;
            if (i_issue_fire) begin
                cnt_issued <= cnt_issued + 1;
            end
            if (fence_pop) begin
                cnt_fences <= cnt_fences + 1;
            end
        end
    end

endmodule

// ==== source/vfu_insn_queues.sv ====
`timescale 1ns/1ns

module vfu_insn_queues import vfu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    vfu_req_if.dst    req,
    output logic      o_empty,
    output logic      o_issue_valid,
    input  logic      i_issue_ready,
    output insn_t     o_issue_insn,
    output xlen_t     o_issue_data0,
    output xlen_t     o_issue_data1,
    output state_id_t o_issue_state,
    output logic      o_issue_fire,
    output req_id_t   o_issue_id
);

    logic [NUM_STATES-1:0]    q_push;
    logic [NUM_STATES-1:0]    q_pop;
    logic [NUM_STATES-1:0]    q_valid;
    logic [NUM_STATES-1:0]    q_full;
    logic [QUEUE_ENTRY_W-1:0] q_in;
    logic [QUEUE_ENTRY_W-1:0] q_data [NUM_STATES];

    state_id_t rr_ptr;
    state_id_t sel;

    assign q_in     = {req.id, req.insn, req.data0, req.data1};
    assign req.full = q_full[req.state];

    for (genvar s = 0; s < NUM_STATES; s++) begin : g_queue
        assign q_push[s] = req.valid & ~q_full[s] & (req.state == state_id_t'(s));
        assign q_pop[s]  = o_issue_fire & (sel == state_id_t'(s));

        vfu_fifo #(
            .WIDTH (QUEUE_ENTRY_W),
            .DEPTH (QUEUE_DEPTH)
        ) u_queue (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_push  (q_push[s]),
            .i_pop   (q_pop[s]),
            .i_data  (q_in),
            .o_data  (q_data[s]),
            .o_valid (q_valid[s]),
            .o_full  (q_full[s])
        );
    end

    ////////////////////
    // Round-robin issue
    ////////////////////

    // Nearest non-empty queue at or after the pointer
    always_comb begin
        sel = rr_ptr;
        for (int i = NUM_STATES - 1; i >= 0; i--) begin
            if (q_valid[rr_ptr + state_id_t'(i)]) begin
                sel = rr_ptr + state_id_t'(i);
            end
        end
    end

    assign o_empty       = ~|q_valid;
    assign o_issue_valid = |q_valid;
    assign o_issue_fire  = o_issue_valid & i_issue_ready;
    assign o_issue_state = sel;

    assign {o_issue_id, o_issue_insn, o_issue_data0, o_issue_data1} = q_data[sel];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rr_ptr <= '0;
        end else if (o_issue_fire) begin
            rr_ptr <= sel + state_id_t'(1);
        end
    end

endmodule

// ==== source/vfu_frontend.sv ====
`timescale 1ns/1ns

module vfu_frontend import vfu_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  req_id_t   i_req_id,
    input  state_id_t i_req_state,
    input  func_t     i_req_func,
    input  insn_t     i_req_insn,
    input  xlen_t     i_req_data0,
    input  xlen_t     i_req_data1,
    input  logic      i_queues_empty,
    input  logic      i_rvv_pending,
    vfu_req_if.src    req,
    vfu_sys_if.src    sys
);

    logic                   buf_push;
    logic                   buf_pop;
    logic                   buf_valid;
    logic                   buf_full;
    logic [REQ_ENTRY_W-1:0] buf_in;
    logic [REQ_ENTRY_W-1:0] buf_out;

    req_id_t   head_id;
    state_id_t head_state;
    func_t     head_func;
    insn_t     head_insn;
    xlen_t     head_data0;
    xlen_t     head_data1;

    logic head_fence;
    logic head_perf;
    logic head_vec;
    logic fence_ok;

    ////////////////////
    // Request buffer
    ////////////////////

    assign o_req_ready = ~buf_full & ~sys.full;
    assign buf_push    = i_req_valid & o_req_ready;
    assign buf_in      = {i_req_id, i_req_state, i_req_func, i_req_insn, i_req_data0, i_req_data1};

    vfu_fifo #(
        .WIDTH (REQ_ENTRY_W),
        .DEPTH (REQ_DEPTH)
    ) u_req_buf (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (buf_push),
        .i_pop   (buf_pop),
        .i_data  (buf_in),
        .o_data  (buf_out),
        .o_valid (buf_valid),
        .o_full  (buf_full)
    );

    assign {head_id, head_state, head_func, head_insn, head_data0, head_data1} = buf_out;

    ////////////////////
    // Head decode
    ////////////////////

    assign head_fence = is_fence(head_insn, head_func);
    assign head_perf  = is_perf(head_insn, head_func);
    assign head_vec   = ~head_fence & ~head_perf;

    // Fence waits for drained queues and no result in flight
    assign fence_ok = i_queues_empty & ~i_rvv_pending & ~sys.full;

    always_comb begin
        buf_pop = 1'b0;
        if (buf_valid) begin
            if (head_vec) begin
                buf_pop = ~req.full;
            end else if (head_perf) begin
                buf_pop = ~sys.full;
            end else begin
                buf_pop = fence_ok;
            end
        end
    end

    assign req.valid = buf_valid & head_vec;
    assign req.state = head_state;
    assign req.insn  = head_insn;
    assign req.data0 = head_data0;
    assign req.data1 = head_data1;
    assign req.id    = head_id;

    assign sys.fence_push = buf_pop & head_fence;
    assign sys.perf_push  = buf_pop & head_perf;
    assign sys.id         = head_id;
    assign sys.sel        = cnt_sel_t'(head_func[0]);

endmodule

// ==== source/vfu_fifo.sv ====
`timescale 1ns/1ns

module vfu_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data,
    output logic             o_valid,
    output logic             o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign o_valid = (count != '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_data  = mem[rd_ptr];

    assign wr_en = i_push & ~o_full;
    assign rd_en = i_pop & o_valid;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // Push and pop together leave count alone
            if (wr_en && !rd_en) begin
                count <= count + CNT_W'(1);
            end else if (rd_en && !wr_en) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

// ==== source/vfu_sys_if.sv ====
`timescale 1ns/1ns

interface vfu_sys_if import vfu_pkg::*; ();

    logic     fence_push;
    logic     perf_push;
    req_id_t  id;
    cnt_sel_t sel;
    // Fence or perf id buffer is full
    logic     full;

    modport src (
        output fence_push, perf_push, id, sel,
        input  full
    );

    modport dst (
        input  fence_push, perf_push, id, sel,
        output full
    );

endinterface

// ==== source/vfu_req_if.sv ====
`timescale 1ns/1ns

interface vfu_req_if import vfu_pkg::*; ();

    logic      valid;
    state_id_t state;
    insn_t     insn;
    xlen_t     data0;
    xlen_t     data1;
    req_id_t   id;
    // Queue picked by state is full
    logic      full;

    modport src (
        output valid, state, insn, data0, data1, id,
        input  full
    );

    modport dst (
        input  valid, state, insn, data0, data1, id,
        output full
    );

endinterface

// ==== source/vfu_pkg.sv ====
package vfu_pkg;

    ////////////////////
    // Widths and depths
    ////////////////////

    localparam int XLEN        = 32;
    localparam int INSN_W      = 32;
    localparam int FUNC_W      = 10;
    localparam int REQ_ID_W    = 4;
    localparam int STATE_ID_W  = 1;
    localparam int NUM_STATES  = 2**STATE_ID_W;
    localparam int REQ_DEPTH   = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int RESP_DEPTH  = 8;

    // Packed entry widths of the request buffer and the instruction queues
    localparam int REQ_ENTRY_W   = REQ_ID_W + STATE_ID_W + FUNC_W + INSN_W + 2*XLEN;
    localparam int QUEUE_ENTRY_W = REQ_ID_W + INSN_W + 2*XLEN;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INSN_W-1:0]     insn_t;
    typedef logic [FUNC_W-1:0]     func_t;
    typedef logic [REQ_ID_W-1:0]   req_id_t;
    typedef logic [STATE_ID_W-1:0] state_id_t;
    typedef logic                  cnt_sel_t;

    localparam cnt_sel_t CNT_ISSUED = 1'b0;
    localparam cnt_sel_t CNT_FENCES = 1'b1;

    typedef enum logic [1:0] {
        FENCE = 2'd0,
        RVV   = 2'd1,
        PERF  = 2'd2
    } resp_port_t;

    ////////////////////
    // Decode
    ////////////////////

    localparam logic [6:0] CX_OPCODE       = 7'b0001011;
    localparam func_t      FUNC_FENCE_BASE = 10'b1111110000;
    localparam func_t      FUNC_PERF_BASE  = 10'b0000000000;

    // Fence covers the four codes 1111110000 to 1111110011
    function automatic logic is_fence(insn_t insn, func_t func);
        return (insn[6:0] == CX_OPCODE) && (func[FUNC_W-1:2] == FUNC_FENCE_BASE[FUNC_W-1:2]);
    endfunction

    // Perf query, lowest func bit picks the counter
    function automatic logic is_perf(insn_t insn, func_t func);
        return (insn[6:0] == CX_OPCODE) && (func[FUNC_W-1:5] == FUNC_PERF_BASE[FUNC_W-1:5]);
    endfunction

endpackage
